//--- hdl/stb_consts.svh
`ifndef STB_CONSTS_SVH
`define STB_CONSTS_SVH

// entries in the per-thread store buffer
`define STB_DEPTH 8

// encoded entry index width
`define STB_PTR_W 3

// pointer with wrap bit, also wide enough for a full count
`define STB_CNT_W 4

`endif

//--- hdl/stb_ptr_pkg.sv
`default_nettype none
`include "stb_consts.svh"

package stb_ptr_pkg;

   // encoded entry index
   typedef logic [`STB_PTR_W-1:0] stb_ptr_t;

   // pointer plus wrap bit, so full and empty differ
   typedef logic [`STB_CNT_W-1:0] stb_wrap_t;

   // one-hot select or per-entry vector
   typedef logic [`STB_DEPTH-1:0] stb_vec_t;

   // index to one-hot
   function automatic stb_vec_t stb_decode(input stb_ptr_t ptr);
      stb_vec_t vec;
      vec = '0;
      vec[ptr] = 1'b1;
      return vec;
   endfunction

   // one-hot to index, or-tree style so a clean one-hot gives its index
   function automatic stb_ptr_t stb_encode(input stb_vec_t vec);
      stb_ptr_t ptr;
      ptr = '0;
      for (int i = 0; i < `STB_DEPTH; i++) begin
         if (vec[i]) begin
            ptr = ptr | stb_ptr_t'(i);
         end
      end
      return ptr;
   endfunction

endpackage

`default_nettype wire

//--- hdl/stb_entry_pkg.sv
`default_nettype none
`include "stb_consts.svh"

package stb_entry_pkg;

   // stores held, 0 to STB_DEPTH inclusive
   typedef logic [`STB_CNT_W-1:0] stb_cnt_t;

   // one bit per entry: valid, committed or acked
   typedef logic [`STB_DEPTH-1:0] stb_state_vec_t;

endpackage

`default_nettype wire

//--- hdl/stb_wptr.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module stb_wptr
   import stb_ptr_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      stb_cam_wvld_m,
   output stb_wrap_t wptr,
   output stb_ptr_t  stb_wrptr,
   output stb_ptr_t  stb_wrptr_prev,
   output stb_vec_t  inflight_vld_g
);

   stb_wrap_t wptr_prev;
   stb_vec_t  dec_wptr_m;
   stb_vec_t  dec_wptr_g;
   logic      stb_cam_wvld_g;

   // ============================================================
   // write pointer
   // ============================================================
   // the producer only writes when an entry is free
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wptr <= '0;
      end else if (stb_cam_wvld_m) begin
         wptr <= wptr + stb_wrap_t'(1);
      end
   end

   // newest written entry is one behind the pointer
   assign wptr_prev      = wptr - stb_wrap_t'(1);
   assign stb_wrptr      = wptr[`STB_PTR_W-1:0];
   assign stb_wrptr_prev = wptr_prev[`STB_PTR_W-1:0];

   // ============================================================
   // m to g staging
   // ============================================================
   // decode taken before the increment, so it names the entry being written
   assign dec_wptr_m = stb_decode(wptr[`STB_PTR_W-1:0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stb_cam_wvld_g <= 1'b0;
      end else begin
         stb_cam_wvld_g <= stb_cam_wvld_m;
      end
   end

   // decoded pointer follows the store into the g stage
   always_ff @(posedge clk) begin
      dec_wptr_g <= dec_wptr_m;
   end

   // entry in the g stage sets its valid bit on the next edge
   assign inflight_vld_g = dec_wptr_g & {`STB_DEPTH{stb_cam_wvld_g}};

endmodule

`default_nettype wire

//--- hdl/stb_dfq_rptr.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module stb_dfq_rptr
   import stb_ptr_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      st_ack_dq_stb,
   output stb_wrap_t rptr_dfq,
   output stb_vec_t  dec_rptr_dfq,
   output stb_vec_t  dq_clr_d2
);

   stb_vec_t dqptr_d1;
   stb_vec_t dqptr_d2;
   logic     dq_vld_d1;
   logic     dq_vld_d2;

   // ============================================================
   // dequeue read pointer
   // ============================================================
   // points at the oldest entry and steps once per dfq retire
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rptr_dfq <= '0;
      end else if (st_ack_dq_stb) begin
         rptr_dfq <= rptr_dfq + stb_wrap_t'(1);
      end
   end

   // the oldest entry in one-hot form also breaks the full-queue deadlock in the pick
   assign dec_rptr_dfq = stb_decode(rptr_dfq[`STB_PTR_W-1:0]);

   // ============================================================
   // two-stage dequeue staging
   // ============================================================
   // dequeue strobe delayed two cycles
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dq_vld_d1 <= 1'b0;
         dq_vld_d2 <= 1'b0;
      end else begin
         dq_vld_d1 <= st_ack_dq_stb;
         dq_vld_d2 <= dq_vld_d1;
      end
   end

   // captured before the pointer moves, so d1 holds the retired entry
   always_ff @(posedge clk) begin
      dqptr_d1 <= dec_rptr_dfq;
      dqptr_d2 <= dqptr_d1;
   end

   // entry to invalidate at the next edge
   assign dq_clr_d2 = dqptr_d2 & {`STB_DEPTH{dq_vld_d2}};

endmodule

`default_nettype wire

//--- hdl/stb_pcx_pick.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module stb_pcx_pick
   import stb_ptr_pkg::*;
   import stb_entry_pkg::*;
(
   input  stb_state_vec_t state_vld,
   input  stb_state_vec_t state_ack,
   input  stb_state_vec_t ced_spec,
   input  stb_vec_t       inflight_vld_g,
   input  stb_vec_t       dec_rptr_dfq,
   output stb_vec_t       dec_rptr_pcx,
   output stb_ptr_t       stb_pcx_rptr,
   output logic           stb_rd_for_pcx
);

   logic           any_vld_unacked;
   stb_vec_t       inflight_issue;
   stb_state_vec_t pred_vld;
   stb_state_vec_t pred_ack;
   stb_vec_t       cand;
   stb_vec_t       order_ok;

   // ============================================================
   // eligibility
   // ============================================================
   // an in-flight write may only issue when nothing older is waiting on an ack
   assign any_vld_unacked = |(state_vld & ~state_ack);
   assign inflight_issue  = inflight_vld_g & {`STB_DEPTH{~any_vld_unacked}};

   // valid or issuable in-flight, and not committed or being requested
   assign cand = (inflight_issue | state_vld) & ~ced_spec;

   // predecessor state, rotated so bit i sees entry i-1 around the circle
   assign pred_vld = {state_vld[`STB_DEPTH-2:0], state_vld[`STB_DEPTH-1]};
   assign pred_ack = {state_ack[`STB_DEPTH-2:0], state_ack[`STB_DEPTH-1]};

   // ordering terms
   //   predecessor valid and acked
   //   predecessor empty
   //   oldest entry, which can always go (full queue deadlock)
   assign order_ok = (pred_vld & pred_ack) | ~pred_vld | dec_rptr_dfq;

   // ============================================================
   // select and encode
   // ============================================================
   // circular queue with one ack outstanding keeps this one-hot
   assign dec_rptr_pcx = cand & order_ok;

   assign stb_pcx_rptr   = stb_encode(dec_rptr_pcx);
   assign stb_rd_for_pcx = |dec_rptr_pcx;

endmodule

`default_nettype wire

//--- hdl/stb_entry_state.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module stb_entry_state
   import stb_ptr_pkg::*;
   import stb_entry_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           pcx_rq_for_stb,
   input  logic           pcx_req_squash,
   input  logic           cpx_st_ack,
   input  stb_vec_t       inflight_vld_g,
   input  stb_vec_t       dq_clr_d2,
   input  stb_vec_t       dec_rptr_pcx,
   output stb_state_vec_t state_vld,
   output stb_state_vec_t state_ack,
   output stb_state_vec_t ced_spec,
   output stb_ptr_t       stb_crnt_ack_id
);

   stb_vec_t       ackptr;
   stb_state_vec_t state_ced;
   stb_state_vec_t ced_set;
   stb_state_vec_t ack_set;
   logic           rq_d1;
   logic           rq_d2;
   logic           squash_d2;
   logic           st_vld_rq_d2;
   logic           skid_ced;

   // ============================================================
   // ack pointer
   // ============================================================
   // only one store outstanding to the crossbar, so one pointer is enough
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ackptr <= '0;
      end else if (pcx_rq_for_stb) begin
         ackptr <= dec_rptr_pcx;
      end
   end

   assign stb_crnt_ack_id = stb_encode(ackptr);

   // ============================================================
   // request staging
   // ============================================================
   // squash arrives one cycle after the request, lines up with rq_d1
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rq_d1     <= 1'b0;
         rq_d2     <= 1'b0;
         squash_d2 <= 1'b0;
      end else begin
         rq_d1     <= pcx_rq_for_stb;
         rq_d2     <= rq_d1;
         squash_d2 <= pcx_req_squash;
      end
   end

   assign st_vld_rq_d2 = rq_d2 & ~squash_d2;

   // hold the entry out of the pick until ced is known
   // a squashed entry comes back three cycles after its request
   assign skid_ced = rq_d1 | rq_d2;
   assign ced_spec = (ackptr & {`STB_DEPTH{skid_ced}}) | state_ced;

   // ============================================================
   // per-entry state
   // ============================================================
   assign ced_set = ackptr & {`STB_DEPTH{st_vld_rq_d2}};
   assign ack_set = ackptr & {`STB_DEPTH{cpx_st_ack}};

   // dequeue clear wins over any set in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_vld <= '0;
         state_ced <= '0;
         state_ack <= '0;
      end else begin
         state_vld <= ~dq_clr_d2 & (inflight_vld_g | state_vld);
         state_ced <= ~dq_clr_d2 & (ced_set | state_ced);
         state_ack <= ~dq_clr_d2 & (ack_set | state_ack);
      end
   end

endmodule

`default_nettype wire

//--- hdl/stb_occupancy.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module stb_occupancy
   import stb_ptr_pkg::*;
   import stb_entry_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  stb_wrap_t      wptr,
   input  stb_wrap_t      rptr_dfq,
   input  stb_state_vec_t state_vld,
   output stb_cnt_t       lsu_stbcnt,
   output logic           stb_full,
   output logic           lsu_stb_empty
);

   stb_wrap_t wptr_w2;
   logic      full_w2;

   // delayed write pointer, stores still in the g stage are not counted
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wptr_w2  <= '0;
         stb_full <= 1'b0;
      end else begin
         wptr_w2  <= wptr;
         stb_full <= full_w2;
      end
   end

   // wrap bits make the difference exact up to a full buffer
   assign lsu_stbcnt = stb_cnt_t'(wptr_w2 - rptr_dfq);

   // full flag trips one short of depth, then flopped for timing
   assign full_w2 = (lsu_stbcnt == stb_cnt_t'(`STB_DEPTH - 1));

   assign lsu_stb_empty = ~(|state_vld);

endmodule

`default_nettype wire

//--- hdl/stb_ctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module stb_ctl_top
   import stb_ptr_pkg::*;
   import stb_entry_pkg::*;
(
   input  logic           clk,
   input  logic           rst_n,
   input  logic           stb_cam_wvld_m,
   input  logic           pcx_rq_for_stb,
   input  logic           pcx_req_squash,
   input  logic           cpx_st_ack,
   input  logic           st_ack_dq_stb,
   output stb_ptr_t       stb_wrptr,
   output stb_ptr_t       stb_wrptr_prev,
   output stb_ptr_t       stb_pcx_rptr,
   output logic           stb_rd_for_pcx,
   output stb_ptr_t       stb_crnt_ack_id,
   output stb_cnt_t       lsu_stbcnt,
   output logic           stb_full,
   output logic           lsu_stb_empty,
   output stb_state_vec_t stb_state_vld
);

   // pointers and their one-hot forms
   stb_wrap_t      wptr;
   stb_wrap_t      rptr_dfq;
   stb_vec_t       inflight_vld_g;
   stb_vec_t       dec_rptr_dfq;
   stb_vec_t       dq_clr_d2;
   stb_vec_t       dec_rptr_pcx;
   // entry state toward the pick
   stb_state_vec_t state_ack;
   stb_state_vec_t ced_spec;

   stb_wptr u_wptr (
      .clk            (clk),
      .rst_n          (rst_n),
      .stb_cam_wvld_m (stb_cam_wvld_m),
      .wptr           (wptr),
      .stb_wrptr      (stb_wrptr),
      .stb_wrptr_prev (stb_wrptr_prev),
      .inflight_vld_g (inflight_vld_g)
   );

   stb_dfq_rptr u_dfq_rptr (
      .clk           (clk),
      .rst_n         (rst_n),
      .st_ack_dq_stb (st_ack_dq_stb),
      .rptr_dfq      (rptr_dfq),
      .dec_rptr_dfq  (dec_rptr_dfq),
      .dq_clr_d2     (dq_clr_d2)
   );

   stb_entry_state u_entry_state (
      .clk             (clk),
      .rst_n           (rst_n),
      .pcx_rq_for_stb  (pcx_rq_for_stb),
      .pcx_req_squash  (pcx_req_squash),
      .cpx_st_ack      (cpx_st_ack),
      .inflight_vld_g  (inflight_vld_g),
      .dq_clr_d2       (dq_clr_d2),
      .dec_rptr_pcx    (dec_rptr_pcx),
      .state_vld       (stb_state_vld),
      .state_ack       (state_ack),
      .ced_spec        (ced_spec),
      .stb_crnt_ack_id (stb_crnt_ack_id)
   );

   stb_pcx_pick u_pcx_pick (
      .state_vld      (stb_state_vld),
      .state_ack      (state_ack),
      .ced_spec       (ced_spec),
      .inflight_vld_g (inflight_vld_g),
      .dec_rptr_dfq   (dec_rptr_dfq),
      .dec_rptr_pcx   (dec_rptr_pcx),
      .stb_pcx_rptr   (stb_pcx_rptr),
      .stb_rd_for_pcx (stb_rd_for_pcx)
   );

   stb_occupancy u_occupancy (
      .clk           (clk),
      .rst_n         (rst_n),
      .wptr          (wptr),
      .rptr_dfq      (rptr_dfq),
      .state_vld     (stb_state_vld),
      .lsu_stbcnt    (lsu_stbcnt),
      .stb_full      (stb_full),
      .lsu_stb_empty (lsu_stb_empty)
   );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   localparam int HALF_PERIOD_NS = 5;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // reset held low across the first three rising edges
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/tb_stb_ctl.sv
`timescale 1ns/1ps
`default_nettype none
`include "stb_consts.svh"

module tb_stb_ctl
   import stb_ptr_pkg::*;
   import stb_entry_pkg::*;
();

   localparam int MAX_ROWS      = 40;
   localparam int CLK_PERIOD_NS = 10;

   // one operation per row applied at a single edge
   typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_REQ, OP_SQUASH, OP_ACK, OP_DEQ} op_e;

   logic           clk;
   logic           rst_n;
   logic           stb_cam_wvld_m;
   logic           pcx_rq_for_stb;
   logic           pcx_req_squash;
   logic           cpx_st_ack;
   logic           st_ack_dq_stb;
   stb_ptr_t       stb_wrptr;
   stb_ptr_t       stb_wrptr_prev;
   stb_ptr_t       stb_pcx_rptr;
   logic           stb_rd_for_pcx;
   stb_ptr_t       stb_crnt_ack_id;
   stb_cnt_t       lsu_stbcnt;
   logic           stb_full;
   logic           lsu_stb_empty;
   stb_state_vec_t stb_state_vld;

   // stimulus and expected pick side results for each row
   string    row_name   [MAX_ROWS];
   op_e      row_op     [MAX_ROWS];
   int       row_settle [MAX_ROWS];
   stb_ptr_t row_ack_id [MAX_ROWS];
   stb_ptr_t row_pick   [MAX_ROWS];
   logic     row_rd     [MAX_ROWS];
   logic     row_full   [MAX_ROWS];
   int       n_rows;

   // reference model counts of stores written and retired, with wrap bit
   stb_wrap_t n_wr;
   stb_wrap_t n_dq;

   int n_checks;
   int n_errors;
   int watchdog_ns;

   tb_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   stb_ctl_top DUT (
      .clk             (clk),
      .rst_n           (rst_n),
      .stb_cam_wvld_m  (stb_cam_wvld_m),
      .pcx_rq_for_stb  (pcx_rq_for_stb),
      .pcx_req_squash  (pcx_req_squash),
      .cpx_st_ack      (cpx_st_ack),
      .st_ack_dq_stb   (st_ack_dq_stb),
      .stb_wrptr       (stb_wrptr),
      .stb_wrptr_prev  (stb_wrptr_prev),
      .stb_pcx_rptr    (stb_pcx_rptr),
      .stb_rd_for_pcx  (stb_rd_for_pcx),
      .stb_crnt_ack_id (stb_crnt_ack_id),
      .lsu_stbcnt      (lsu_stbcnt),
      .stb_full        (stb_full),
      .lsu_stb_empty   (lsu_stb_empty),
      .stb_state_vld   (stb_state_vld)
   );

   // ============================================================
   // compare tasks
   // ============================================================
   task automatic ptr_compare(input string test, input string sig,
                              input stb_ptr_t exp, input stb_ptr_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("mismatch %s %s: expected %0d, actual %0d", test, sig, exp, act);
      end
   endtask

   task automatic cnt_compare(input string test, input string sig,
                              input stb_cnt_t exp, input stb_cnt_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("mismatch %s %s: expected %0d, actual %0d", test, sig, exp, act);
      end
   endtask

   task automatic vec_compare(input string test, input string sig,
                              input stb_state_vec_t exp, input stb_state_vec_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("mismatch %s %s: expected %b, actual %b", test, sig, exp, act);
      end
   endtask

   task automatic flag_compare(input string test, input string sig,
                               input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("mismatch %s %s: expected %b, actual %b", test, sig, exp, act);
      end
   endtask

   // ============================================================
   // reference model and row handling
   // ============================================================
   // entries from the oldest up to the newest written are valid once settled
   function automatic stb_state_vec_t expected_vld(input stb_wrap_t wr, input stb_wrap_t rd);
      stb_state_vec_t vec;
      stb_cnt_t       held;
      stb_ptr_t       idx;
      vec  = '0;
      held = stb_cnt_t'(wr - rd);
      idx  = rd[`STB_PTR_W-1:0];
      for (int j = 0; j < `STB_DEPTH; j++) begin
         if (j < int'(held)) begin
            vec[idx] = 1'b1;
         end
         idx = idx + stb_ptr_t'(1);
      end
      return vec;
   endfunction

   task automatic add_row(input string name, input op_e op, input int settle,
                          input stb_ptr_t ack_id, input stb_ptr_t pick,
                          input logic rd, input logic full);
      row_name[n_rows]   = name;
      row_op[n_rows]     = op;
      row_settle[n_rows] = settle;
      row_ack_id[n_rows] = ack_id;
      row_pick[n_rows]   = pick;
      row_rd[n_rows]     = rd;
      row_full[n_rows]   = full;
      n_rows++;
   endtask

   // strobe for one edge then wait the settle edges and sample at the falling edge
   task automatic apply_row(input int r);
      stb_cnt_t exp_cnt;
      stb_wrap_t exp_prev;
      stb_wrap_t vis_wr;
      @(posedge clk);
      stb_cam_wvld_m <= (row_op[r] == OP_WRITE);
      pcx_rq_for_stb <= (row_op[r] == OP_REQ) || (row_op[r] == OP_SQUASH);
      cpx_st_ack     <= (row_op[r] == OP_ACK);
      st_ack_dq_stb  <= (row_op[r] == OP_DEQ);
      pcx_req_squash <= 1'b0;
      @(posedge clk);
      stb_cam_wvld_m <= 1'b0;
      pcx_rq_for_stb <= 1'b0;
      cpx_st_ack     <= 1'b0;
      st_ack_dq_stb  <= 1'b0;
      // squash lines up with the cycle after the request
      pcx_req_squash <= (row_op[r] == OP_SQUASH);
      if (row_op[r] == OP_WRITE) begin
         n_wr = n_wr + stb_wrap_t'(1);
      end
      if (row_op[r] == OP_DEQ) begin
         n_dq = n_dq + stb_wrap_t'(1);
      end
      repeat (row_settle[r]) begin
         @(posedge clk);
         pcx_req_squash <= 1'b0;
      end
      @(negedge clk);
      // a store seen by one edge only is still in the g stage and not yet counted
      vis_wr = n_wr;
      if ((row_op[r] == OP_WRITE) && (row_settle[r] == 0)) begin
         vis_wr = n_wr - stb_wrap_t'(1);
      end
      exp_cnt  = stb_cnt_t'(vis_wr - n_dq);
      exp_prev = n_wr - stb_wrap_t'(1);
      ptr_compare(row_name[r], "stb_wrptr", n_wr[`STB_PTR_W-1:0], stb_wrptr);
      ptr_compare(row_name[r], "stb_wrptr_prev", exp_prev[`STB_PTR_W-1:0], stb_wrptr_prev);
      ptr_compare(row_name[r], "stb_crnt_ack_id", row_ack_id[r], stb_crnt_ack_id);
      ptr_compare(row_name[r], "stb_pcx_rptr", row_pick[r], stb_pcx_rptr);
      flag_compare(row_name[r], "stb_rd_for_pcx", row_rd[r], stb_rd_for_pcx);
      cnt_compare(row_name[r], "lsu_stbcnt", exp_cnt, lsu_stbcnt);
      flag_compare(row_name[r], "stb_full", row_full[r], stb_full);
      flag_compare(row_name[r], "lsu_stb_empty", (exp_cnt == '0), lsu_stb_empty);
      vec_compare(row_name[r], "stb_state_vld", expected_vld(vis_wr, n_dq), stb_state_vld);
   endtask

   // ============================================================
   // row table
   // ============================================================
   // name, op, settle, ack id, pick pointer, read strobe, full
   task automatic build_table();
      add_row("reset_idle",   OP_IDLE,   2, 0, 0, 0, 0);
      add_row("write_e0",     OP_WRITE,  2, 0, 0, 1, 0);
      add_row("write_e1",     OP_WRITE,  2, 0, 0, 1, 0);
      add_row("write_e2",     OP_WRITE,  2, 0, 0, 1, 0);
      // with one ack outstanding the pick stalls until the ack
      add_row("req_e0",       OP_REQ,    2, 0, 0, 0, 0);
      add_row("ack_e0",       OP_ACK,    2, 0, 1, 1, 0);
      // a squashed entry is held out for two edges and then picked again
      add_row("squash_hold",  OP_SQUASH, 1, 1, 0, 0, 0);
      add_row("squash_retry", OP_SQUASH, 2, 1, 1, 1, 0);
      add_row("req_e1",       OP_REQ,    2, 1, 0, 0, 0);
      add_row("ack_e1",       OP_ACK,    2, 1, 2, 1, 0);
      add_row("req_e2",       OP_REQ,    2, 2, 0, 0, 0);
      add_row("ack_e2",       OP_ACK,    2, 2, 0, 0, 0);
      add_row("deq_e0",       OP_DEQ,    2, 2, 0, 0, 0);
      add_row("deq_e1",       OP_DEQ,    2, 2, 0, 0, 0);
      add_row("deq_e2",       OP_DEQ,    2, 2, 0, 0, 0);
      // seven stores from entry 3 wrap the write pointer past 7
      // the first one is picked from the g stage before its valid bit is set
      add_row("fill_e3",      OP_WRITE,  0, 2, 3, 1, 0);
      add_row("fill_e4",      OP_WRITE,  2, 2, 3, 1, 0);
      add_row("fill_e5",      OP_WRITE,  2, 2, 3, 1, 0);
      add_row("fill_e6",      OP_WRITE,  2, 2, 3, 1, 0);
      add_row("fill_e7",      OP_WRITE,  2, 2, 3, 1, 0);
      add_row("fill_e0",      OP_WRITE,  2, 2, 3, 1, 0);
      add_row("fill_e1",      OP_WRITE,  1, 2, 3, 1, 0);
      add_row("full_late",    OP_IDLE,   0, 2, 3, 1, 1);
      add_row("req_e3",       OP_REQ,    2, 3, 0, 0, 1);
      add_row("ack_e3",       OP_ACK,    2, 3, 4, 1, 1);
      add_row("deq_e3",       OP_DEQ,    2, 3, 4, 1, 0);
      add_row("write_wrap",   OP_WRITE,  2, 3, 4, 1, 1);
      // all eight entries held, so only the oldest entry term lets entry 4 go
      // full tracks a count of 7 and falls again at 8
      add_row("write_full8",  OP_WRITE,  2, 3, 4, 1, 0);
      // read pointer walks past 7 and sets its wrap bit
      add_row("deq_e4",       OP_DEQ,    2, 3, 5, 1, 1);
      add_row("deq_e5",       OP_DEQ,    2, 3, 6, 1, 0);
      add_row("deq_e6",       OP_DEQ,    2, 3, 7, 1, 0);
      add_row("deq_e7",       OP_DEQ,    2, 3, 0, 1, 0);
   endtask

   // ============================================================
   // main sequence and watchdog
   // ============================================================
   initial begin
      int budget;
      stb_cam_wvld_m = 1'b0;
      pcx_rq_for_stb = 1'b0;
      pcx_req_squash = 1'b0;
      cpx_st_ack     = 1'b0;
      st_ack_dq_stb  = 1'b0;
      n_rows         = 0;
      n_wr           = '0;
      n_dq           = '0;
      n_checks       = 0;
      n_errors       = 0;
      watchdog_ns    = 0;
      build_table();
      // twice the reset cycles plus two strobe edges and the settle edges per row
      budget = 4;
      for (int r = 0; r < n_rows; r++) begin
         budget += row_settle[r] + 2;
      end
      watchdog_ns = budget * CLK_PERIOD_NS * 2;
      wait (rst_n === 1'b1);
      for (int r = 0; r < n_rows; r++) begin
         apply_row(r);
      end
      $display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      wait (watchdog_ns != 0);
      #(watchdog_ns);
      $display("timeout: the rows did not complete within %0d ns", watchdog_ns);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/stb_ptr_pkg.sv
hdl/stb_entry_pkg.sv
hdl/stb_wptr.sv
hdl/stb_dfq_rptr.sv
hdl/stb_pcx_pick.sv
hdl/stb_entry_state.sv
hdl/stb_occupancy.sv
hdl/stb_ctl_top.sv
verif/tb_clk_gen.sv
verif/tb_stb_ctl.sv
